// File: csr_unit.f
secv_pkg.sv
csr_access.sv
csr_regs.sv
csr_trap.sv
csr_unit.sv
tb_csr_unit.sv

// File: Makefile
# Verilator build and run for the CSR unit testbench

VERILATOR ?= verilator
TOP       ?= tb_csr_unit
FLIST     ?= csr_unit.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fails on a testbench error"
	@echo "  clean  remove build output"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: tb_csr_unit.sv
// Self-checking testbench for the CSR unit with a shadow model and LFSR stimulus
`default_nettype none

module tb_csr_unit;

    import secv_pkg::*;

    localparam int PERIOD   = 100;
    localparam int N_RAND   = 200;                       // Random CSR requests
    localparam int N_TRAP   = 20;                        // Traps per mtvec mode
    localparam int MAX_CYC  = 8192;                      // Expectation slots
    localparam int WD_CYC   = 16 + 3 * N_RAND + 2 * 6 * N_TRAP + 400; // Watchdog bound

    typedef struct packed {
        logic            illegal;                        // Expected illegal flag
        logic [XLEN-1:0] rdata;                          // Expected old value
        logic            wr;                             // Register changes
        logic [XLEN-1:0] wdata;                          // Unmasked new value
    } ref_t;

    logic            clk_i;
    logic            rst_i;
    logic [HART_W-1:0] hartid_i;
    logic            retire_i;
    logic            req_stb_i;
    csr_req_t        req_i;
    logic            rsp_stb_o;
    csr_rsp_t        rsp_o;
    logic            trap_stb_i;
    trap_req_t       trap_i;
    logic            mret_stb_i;
    logic            redirect_stb_o;
    logic [XLEN-1:0] redirect_pc_o;

    // Shadow register state, after the last driven edge
    logic            s_mie_bit;
    logic            s_mpie_bit;
    logic [XLEN-1:0] s_mie;
    logic [XLEN-1:0] s_mtvec;
    logic [XLEN-1:0] s_mscratch;
    logic [XLEN-1:0] s_mepc;
    logic [XLEN-1:0] s_mcause;
    logic [XLEN-1:0] s_mtval;
    logic [XLEN-1:0] s_mcycle;
    logic [XLEN-1:0] s_minstret;

    // Per-cycle expectations, slot k is seen one edge after step k
    logic            exp_rsp_v [MAX_CYC];
    logic            exp_ill   [MAX_CYC];
    logic [XLEN-1:0] exp_rdata [MAX_CYC];
    logic            exp_red_v [MAX_CYC];
    logic [XLEN-1:0] exp_red_pc[MAX_CYC];

    logic [15:0]     lfsr = 16'd52870;
    int              drv_idx = 0;
    int              errors = 0;
    logic            started = 1'b0;
    logic [11:0]     wr_addrs [8];

    csr_unit dut0 (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .hartid_i       (hartid_i),
        .retire_i       (retire_i),
        .req_stb_i      (req_stb_i),
        .req_i          (req_i),
        .rsp_stb_o      (rsp_stb_o),
        .rsp_o          (rsp_o),
        .trap_stb_i     (trap_stb_i),
        .trap_i         (trap_i),
        .mret_stb_i     (mret_stb_i),
        .redirect_stb_o (redirect_stb_o),
        .redirect_pc_o  (redirect_pc_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(PERIOD / 2) clk_i = ~clk_i;
    end

    // x^16 + x^14 + x^13 + x^11, one step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        logic        fb;
        v = '0;
        for (int b = 0; b < n; b++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[62:0], fb};
        end
        return v;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    function automatic logic [63:0] shadow_read(input logic [11:0] addr, output logic valid);
        valid = 1'b1;
        case (addr)
            12'h300: return {51'd0, 2'b11, 3'd0, s_mpie_bit, 3'd0, s_mie_bit, 3'd0};
            12'h301: return 64'h8000_0000_0010_0100;     // MXL=2, I and U
            12'h304: return s_mie;
            12'h305: return s_mtvec;
            12'h340: return s_mscratch;
            12'h341: return s_mepc;
            12'h342: return s_mcause;
            12'h343: return s_mtval;
            12'hB00: return s_mcycle;
            12'hB02: return s_minstret;
            12'hF11: return MVENDORID;
            12'hF12: return MARCHID;
            12'hF13: return MIMPID;
            12'hF14: return {60'd0, hartid_i};
            default: begin
                valid = 1'b0;
                return 64'd0;
            end
        endcase
    endfunction

    // Expected response and write from the Zicsr rules
    function automatic ref_t csr_ref(input csr_req_t rq);
        ref_t        r;
        logic        valid;
        logic [63:0] old;
        logic [63:0] src;
        old       = shadow_read(rq.addr, valid);
        src       = rq.use_imm ? {59'd0, rq.imm} : rq.rs_val;
        r.wr      = (rq.op == CSR_RW) || (src != 64'd0);
        r.illegal = !valid || ((rq.addr[11:10] == 2'b11) && r.wr);
        r.rdata   = r.illegal ? 64'd0 : old;
        case (rq.op)
            CSR_RS:  r.wdata = old | src;
            CSR_RC:  r.wdata = old & ~src;
            default: r.wdata = src;
        endcase
        if (r.illegal) r.wr = 1'b0;
        return r;
    endfunction

    task automatic apply_write(input logic [11:0] addr, input logic [63:0] d);
        case (addr)
            12'h300: begin
                s_mie_bit  = d[3];
                s_mpie_bit = d[7];
            end
            12'h304: s_mie      = d;
            12'h305: s_mtvec    = {d[63:2], 1'b0, d[0]};   // Mode 0 or 1 only
            12'h340: s_mscratch = d;
            12'h341: s_mepc     = {d[63:2], 2'b00};
            12'h342: s_mcause   = d;
            12'h343: s_mtval    = d;
            12'hB00: s_mcycle   = d;
            12'hB02: s_minstret = d;
            default: ;
        endcase
    endtask

    // One clock cycle, entered and left on a falling edge
    task automatic step(input logic req_v, input csr_req_t rq, input logic trap_v,
                        input trap_req_t tr, input logic mret_v, input logic retire);
        ref_t        r;
        logic [63:0] base;
        req_stb_i  = req_v;
        req_i      = rq;
        trap_stb_i = trap_v;
        trap_i     = tr;
        mret_stb_i = mret_v;
        retire_i   = retire;
        r = csr_ref(rq);
        exp_rsp_v[drv_idx] = req_v;
        exp_ill[drv_idx]   = r.illegal;
        exp_rdata[drv_idx] = r.rdata;
        exp_red_v[drv_idx] = trap_v || mret_v;
        base = s_mtvec & ~64'h3;                         // Mode bits dropped
        if (trap_v) begin
            exp_red_pc[drv_idx] = base;
            if (s_mtvec[0] && tr.is_int) begin
                exp_red_pc[drv_idx] = base + 64'd4 * 64'(tr.cause);  // Vectored interrupt
            end
        end else begin
            exp_red_pc[drv_idx] = s_mepc;                // Pre-update mepc
        end
        s_mcycle = s_mcycle + 64'd1;
        if (retire) s_minstret = s_minstret + 64'd1;
        if (trap_v) begin
            s_mepc     = {tr.pc[63:2], 2'b00};
            s_mcause   = {tr.is_int, 57'd0, tr.cause};
            s_mtval    = tr.tval;
            s_mpie_bit = s_mie_bit;
            s_mie_bit  = 1'b0;
        end else if (mret_v) begin
            s_mie_bit  = s_mpie_bit;
            s_mpie_bit = 1'b1;
        end else if (req_v && r.wr) begin
            apply_write(rq.addr, r.wdata);               // Suppressed by trap or MRET
        end
        drv_idx++;
        @(negedge clk_i);
    endtask

    function automatic csr_req_t make_req(input csr_op_e op, input logic use_imm,
                                          input logic [11:0] addr, input logic [63:0] val);
        csr_req_t rq;
        rq.op      = op;
        rq.use_imm = use_imm;
        rq.addr    = addr;
        rq.rs_val  = val;
        rq.imm     = val[4:0];
        return rq;
    endfunction

    task automatic idle(input int n);
        repeat (n) step(1'b0, '0, 1'b0, '0, 1'b0, 1'b0);
    endtask

    task automatic csr_op(input csr_op_e op, input logic use_imm, input logic [11:0] addr,
                          input logic [63:0] val);
        step(1'b1, make_req(op, use_imm, addr, val), 1'b0, '0, 1'b0, 1'b0);
    endtask

    task automatic random_trap();
        trap_req_t tr;
        tr.is_int = rand_bits(1) != 64'd0;
        tr.cause  = 6'(rand_bits(6));
        tr.pc     = rand_bits(64);
        tr.tval   = rand_bits(64);
        step(1'b0, '0, 1'b1, tr, 1'b0, 1'b0);
    endtask

    task automatic read_trap_csrs();
        csr_op(CSR_RS, 1'b0, CSR_ADDR_MEPC, 64'd0);
        csr_op(CSR_RS, 1'b1, CSR_ADDR_MCAUSE, 64'd0);
        csr_op(CSR_RS, 1'b0, CSR_ADDR_MTVAL, 64'd0);
        csr_op(CSR_RC, 1'b0, CSR_ADDR_MSTATUS, 64'd0);
    endtask

    task automatic random_req();
        csr_op_e op;
        case (rand_bits(2))
            64'd2:   op = CSR_RS;
            64'd3:   op = CSR_RC;
            default: op = CSR_RW;
        endcase
        csr_op(op, rand_bits(1) != 64'd0, wr_addrs[3'(rand_bits(3))], rand_bits(64));
    endtask

    // Compares each registered output against the slot driven one cycle earlier
    initial begin : compare_outputs
        int i;
        i = 0;
        wait (started);
        forever begin
            @(negedge clk_i);
            check("rsp_stb_o", {63'd0, rsp_stb_o}, {63'd0, exp_rsp_v[i]});
            if (exp_rsp_v[i]) begin
                check("rsp_o.rdata", rsp_o.rdata, exp_rdata[i]);
                check("rsp_o.illegal", {63'd0, rsp_o.illegal}, {63'd0, exp_ill[i]});
            end
            check("redirect_stb_o", {63'd0, redirect_stb_o}, {63'd0, exp_red_v[i]});
            if (exp_red_v[i]) check("redirect_pc_o", redirect_pc_o, exp_red_pc[i]);
            i++;
        end
    end

    initial begin : watchdog
        #(WD_CYC * PERIOD);
        $display("Watchdog expired before the tests completed");
        $display("Finished with errors");
        $fatal(1);
    end

    initial begin
        trap_req_t tr;
        wr_addrs = '{CSR_ADDR_MSTATUS, CSR_ADDR_MIE, CSR_ADDR_MTVEC, CSR_ADDR_MSCRATCH,
                     CSR_ADDR_MEPC, CSR_ADDR_MCAUSE, CSR_ADDR_MTVAL, CSR_ADDR_MINSTRET};
        rst_i = 1'b1;
        hartid_i = 4'hA;
        retire_i = 1'b0;
        req_stb_i = 1'b0;
        req_i = '0;
        trap_stb_i = 1'b0;
        trap_i = '0;
        mret_stb_i = 1'b0;
        {s_mie_bit, s_mpie_bit} = 2'b00;
        {s_mie, s_mtvec, s_mscratch, s_mepc} = '0;
        {s_mcause, s_mtval, s_mcycle, s_minstret} = '0;
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        started = 1'b1;

        // Random read-modify-write traffic, gaps or back-to-back
        for (int n = 0; n < N_RAND; n++) begin
            if (rand_bits(2) == 64'd0) idle(1);
            random_req();
        end
        foreach (wr_addrs[a]) csr_op(CSR_RS, 1'b0, wr_addrs[a], 64'd0);

        // Identification registers, misa and illegal accesses
        csr_op(CSR_RS, 1'b0, CSR_ADDR_MVENDORID, 64'd0);
        csr_op(CSR_RS, 1'b1, CSR_ADDR_MARCHID, 64'd0);
        csr_op(CSR_RC, 1'b0, CSR_ADDR_MIMPID, 64'd0);
        csr_op(CSR_RS, 1'b0, CSR_ADDR_MHARTID, 64'd0);
        csr_op(CSR_RS, 1'b0, CSR_ADDR_MISA, 64'd0);
        csr_op(CSR_RW, 1'b0, CSR_ADDR_MISA, 64'd0);      // Legal, ignored
        csr_op(CSR_RS, 1'b0, CSR_ADDR_MISA, 64'd0);
        csr_op(CSR_RW, 1'b0, CSR_ADDR_MVENDORID, 64'd0);
        csr_op(CSR_RS, 1'b1, CSR_ADDR_MHARTID, 64'd5);
        csr_op(CSR_RC, 1'b0, CSR_ADDR_MARCHID, 64'hFF);
        csr_op(CSR_RW, 1'b0, 12'h7C0, 64'd1);
        csr_op(CSR_RS, 1'b0, 12'h3A0, 64'd0);
        for (int n = 0; n < 20; n++) csr_op(CSR_RW, 1'b0, 12'(rand_bits(12)), rand_bits(64));
        csr_op(CSR_RS, 1'b0, CSR_ADDR_MHARTID, 64'd0);

        // Counters
        idle(37);
        csr_op(CSR_RS, 1'b0, CSR_ADDR_MCYCLE, 64'd0);
        for (int n = 0; n < 25; n++) step(1'b0, '0, 1'b0, '0, 1'b0, rand_bits(1) != 64'd0);
        csr_op(CSR_RS, 1'b0, CSR_ADDR_MINSTRET, 64'd0);
        csr_op(CSR_RW, 1'b0, CSR_ADDR_MCYCLE, 64'h0000_1000_0000_0000);
        idle(5);
        csr_op(CSR_RS, 1'b0, CSR_ADDR_MCYCLE, 64'd0);

        // Traps in direct, then vectored mode
        for (int mode = 0; mode < 2; mode++) begin
            csr_op(CSR_RW, 1'b0, CSR_ADDR_MTVEC, {62'(rand_bits(62)), 1'b0, mode[0]});
            csr_op(CSR_RS, 1'b0, CSR_ADDR_MTVEC, 64'd0);
            for (int n = 0; n < N_TRAP; n++) begin
                csr_op(CSR_RS, 1'b1, CSR_ADDR_MSTATUS, 64'd8);   // Set MIE
                random_trap();
                read_trap_csrs();
            end
        end

        // MRET restores MIE and returns to mepc
        csr_op(CSR_RW, 1'b0, CSR_ADDR_MSTATUS, 64'h8);
        random_trap();
        step(1'b0, '0, 1'b0, '0, 1'b1, 1'b0);
        csr_op(CSR_RW, 1'b0, CSR_ADDR_MSTATUS, 64'd0);   // MIE back to 1, then clear MPIE
        step(1'b0, '0, 1'b0, '0, 1'b1, 1'b0);
        csr_op(CSR_RS, 1'b0, CSR_ADDR_MSTATUS, 64'd0);   // MIE restored as 0

        // Write colliding with a trap, then with MRET, then trap beating MRET
        tr = '{is_int: 1'b1, cause: 6'd7, pc: 64'h8000_0123, tval: 64'h55};
        step(1'b1, make_req(CSR_RW, 1'b0, CSR_ADDR_MSCRATCH, 64'hDEAD_BEEF), 1'b1, tr,
             1'b0, 1'b0);
        csr_op(CSR_RS, 1'b0, CSR_ADDR_MSCRATCH, 64'd0);
        step(1'b1, make_req(CSR_RS, 1'b1, CSR_ADDR_MIE, 64'h1F), 1'b0, '0, 1'b1, 1'b0);
        csr_op(CSR_RS, 1'b0, CSR_ADDR_MIE, 64'd0);
        step(1'b0, '0, 1'b1, tr, 1'b1, 1'b0);
        read_trap_csrs();
        idle(3);
        @(posedge clk_i);                                // Last slot compared at the negedge

        if (errors == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Finished with errors");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// File: csr_unit.sv
// Machine-mode CSR unit top, joins access unit, register file and trap unit
`default_nettype none

module csr_unit (
    input  logic                          clk_i,
    input  logic                          rst_i,

    input  logic [secv_pkg::HART_W-1:0]   hartid_i,       // Hardware thread id
    input  logic                          retire_i,       // Instruction retired

    input  logic                          req_stb_i,      // CSR request valid
    input  secv_pkg::csr_req_t            req_i,          // CSR request
    output logic                          rsp_stb_o,      // CSR response valid
    output secv_pkg::csr_rsp_t            rsp_o,          // CSR response

    input  logic                          trap_stb_i,     // Trap event
    input  secv_pkg::trap_req_t           trap_i,         // Trap details
    input  logic                          mret_stb_i,     // MRET executed
    output logic                          redirect_stb_o, // Fetch redirect valid
    output logic [secv_pkg::XLEN-1:0]     redirect_pc_o   // Fetch redirect target
);

    import secv_pkg::*;

    logic            suppress;                           // Drop CSR write this cycle
    logic [11:0]     rd_addr;
    logic [XLEN-1:0] rd_data;
    logic            rd_valid;
    logic            wr_stb;
    csr_wr_t         wr;
    logic            upd_stb;
    trap_upd_t       upd;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;
    logic            mie_bit;
    logic            mpie_bit;

    assign suppress = trap_stb_i || mret_stb_i;          // Trap path owns the edge

    csr_access u_access (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .req_stb_i  (req_stb_i),
        .req_i      (req_i),
        .suppress_i (suppress),
        .rd_addr_o  (rd_addr),
        .rd_data_i  (rd_data),
        .rd_valid_i (rd_valid),
        .wr_stb_o   (wr_stb),
        .wr_o       (wr),
        .rsp_stb_o  (rsp_stb_o),
        .rsp_o      (rsp_o)
    );

    csr_regs u_regs (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .hartid_i   (hartid_i),
        .retire_i   (retire_i),
        .wr_stb_i   (wr_stb),
        .wr_i       (wr),
        .upd_stb_i  (upd_stb),
        .upd_i      (upd),
        .rd_addr_i  (rd_addr),
        .rd_data_o  (rd_data),
        .rd_valid_o (rd_valid),
        .mtvec_o    (mtvec),
        .mepc_o     (mepc),
        .mie_bit_o  (mie_bit),
        .mpie_bit_o (mpie_bit)
    );

    csr_trap u_trap (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .trap_stb_i     (trap_stb_i),
        .trap_i         (trap_i),
        .mret_stb_i     (mret_stb_i),
        .mtvec_i        (mtvec),
        .mepc_i         (mepc),
        .mie_bit_i      (mie_bit),
        .mpie_bit_i     (mpie_bit),
        .upd_stb_o      (upd_stb),
        .upd_o          (upd),
        .redirect_stb_o (redirect_stb_o),
        .redirect_pc_o  (redirect_pc_o)
    );

endmodule

`default_nettype wire

// File: csr_trap.sv
// Trap entry and MRET sequencer, builds trap CSR updates and the redirect target
`default_nettype none

module csr_trap (
    input  logic                          clk_i,
    input  logic                          rst_i,

    input  logic                          trap_stb_i,     // Trap event
    input  secv_pkg::trap_req_t           trap_i,         // Trap details
    input  logic                          mret_stb_i,     // MRET executed

    input  logic [secv_pkg::XLEN-1:0]     mtvec_i,        // Current mtvec
    input  logic [secv_pkg::XLEN-1:0]     mepc_i,         // Current mepc
    input  logic                          mie_bit_i,      // Current MIE
    input  logic                          mpie_bit_i,     // Current MPIE

    output logic                          upd_stb_o,      // Register update strobe
    output secv_pkg::trap_upd_t           upd_o,          // Register update values

    output logic                          redirect_stb_o, // Fetch redirect valid
    output logic [secv_pkg::XLEN-1:0]     redirect_pc_o   // Fetch redirect target
);

    import secv_pkg::*;

    logic [XLEN-1:0] tvec_base;                          // mtvec without mode bits
    logic [XLEN-1:0] vec_offset;                         // 4 x cause for vectored ints
    logic [XLEN-1:0] target_d;                           // Next redirect pc

    assign tvec_base  = {mtvec_i[XLEN-1:2], 2'b00};
    assign vec_offset = (mtvec_i[0] && trap_i.is_int)
                      ? {{(XLEN-8){1'b0}}, trap_i.cause, 2'b00}
                      : '0;

    // Trap beats MRET, MRET returns to the pre-update mepc
    assign target_d = trap_stb_i ? (tvec_base + vec_offset) : mepc_i;

    assign upd_stb_o = trap_stb_i || mret_stb_i;         // Applied on the next edge

    always_comb begin
        upd_o.save   = trap_stb_i;
        upd_o.mepc   = {trap_i.pc[XLEN-1:2], 2'b00};     // Aligned return address
        upd_o.mcause = {trap_i.is_int, {(XLEN-7){1'b0}}, trap_i.cause};
        upd_o.mtval  = trap_i.tval;
        if (trap_stb_i) begin
            upd_o.mie_bit  = 1'b0;                       // Disable interrupts
            upd_o.mpie_bit = mie_bit_i;                  // Stack old MIE
        end else begin
            upd_o.mie_bit  = mpie_bit_i;                 // Restore from stack
            upd_o.mpie_bit = 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            redirect_stb_o <= 1'b0;
        end else begin
            redirect_stb_o <= upd_stb_o;                 // Same edge as CSR update
        end
    end

    always_ff @(posedge clk_i) begin
        if (upd_stb_o) begin
            redirect_pc_o <= target_d;
        end
    end

endmodule

`default_nettype wire

// File: csr_regs.sv
// Machine-mode CSR storage with write masks, counters and combinational read mux
`default_nettype none

module csr_regs (
    input  logic                          clk_i,
    input  logic                          rst_i,

    input  logic [secv_pkg::HART_W-1:0]   hartid_i,   // Hardware thread id
    input  logic                          retire_i,   // Instruction retired

    input  logic                          wr_stb_i,   // CSR write strobe
    input  secv_pkg::csr_wr_t             wr_i,       // CSR write port
    input  logic                          upd_stb_i,  // Trap or MRET update
    input  secv_pkg::trap_upd_t           upd_i,      // Trap CSR values

    input  logic [11:0]                   rd_addr_i,  // Read address
    output logic [secv_pkg::XLEN-1:0]     rd_data_o,  // Read data
    output logic                          rd_valid_o, // Address implemented

    output logic [secv_pkg::XLEN-1:0]     mtvec_o,    // Trap vector to trap unit
    output logic [secv_pkg::XLEN-1:0]     mepc_o,     // Return address to trap unit
    output logic                          mie_bit_o,  // mstatus.MIE
    output logic                          mpie_bit_o  // mstatus.MPIE
);

    import secv_pkg::*;

    logic            mie_bit;                            // mstatus.MIE
    logic            mpie_bit;                           // mstatus.MPIE
    logic [XLEN-1:0] mie;                                // Interrupt enable
    logic [XLEN-1:0] mtvec;                              // Base plus mode in bit 0
    logic [XLEN-1:0] mscratch;
    logic [XLEN-1:0] mepc;                               // Bits 1:0 always zero
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] mtval;
    logic [XLEN-1:0] mcycle;
    logic [XLEN-1:0] minstret;
    logic [XLEN-1:0] mstatus_rd;                         // Assembled mstatus view

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mie_bit  <= 1'b0;
            mpie_bit <= 1'b0;
            mie      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            mcycle <= mcycle + 1'b1;                     // Free running
            if (retire_i) begin
                minstret <= minstret + 1'b1;
            end

            if (upd_stb_i) begin                         // Trap path wins
                mie_bit  <= upd_i.mie_bit;
                mpie_bit <= upd_i.mpie_bit;
                if (upd_i.save) begin                    // Trap entry only, not MRET
                    mepc   <= upd_i.mepc;
                    mcause <= upd_i.mcause;
                    mtval  <= upd_i.mtval;
                end
            end else if (wr_stb_i) begin
                case (wr_i.addr)
                    CSR_ADDR_MSTATUS: begin              // Only MIE and MPIE stored
                        mie_bit  <= wr_i.data[MSTATUS_MIE];
                        mpie_bit <= wr_i.data[MSTATUS_MPIE];
                    end
                    CSR_ADDR_MIE:      mie      <= wr_i.data;
                    CSR_ADDR_MTVEC:    mtvec    <= {wr_i.data[XLEN-1:2], 1'b0, wr_i.data[0]};
                    CSR_ADDR_MSCRATCH: mscratch <= wr_i.data;
                    CSR_ADDR_MEPC:     mepc     <= {wr_i.data[XLEN-1:2], 2'b00};
                    CSR_ADDR_MCAUSE:   mcause   <= wr_i.data;
                    CSR_ADDR_MTVAL:    mtval    <= wr_i.data;
                    CSR_ADDR_MCYCLE:   mcycle   <= wr_i.data;    // Overrides increment
                    CSR_ADDR_MINSTRET: minstret <= wr_i.data;
                    default: ;                           // misa and others ignore writes
                endcase
            end
        end
    end

    always_comb begin
        mstatus_rd                                   = '0;
        mstatus_rd[MSTATUS_MIE]                      = mie_bit;
        mstatus_rd[MSTATUS_MPIE]                     = mpie_bit;
        mstatus_rd[MSTATUS_MPP+1:MSTATUS_MPP]        = 2'b11;    // Machine mode only
    end

    always_comb begin
        rd_data_o  = '0;
        rd_valid_o = 1'b1;
        case (rd_addr_i)
            CSR_ADDR_MSTATUS:   rd_data_o = mstatus_rd;
            CSR_ADDR_MISA:      rd_data_o = MISA_VAL;
            CSR_ADDR_MIE:       rd_data_o = mie;
            CSR_ADDR_MTVEC:     rd_data_o = mtvec;
            CSR_ADDR_MSCRATCH:  rd_data_o = mscratch;
            CSR_ADDR_MEPC:      rd_data_o = mepc;
            CSR_ADDR_MCAUSE:    rd_data_o = mcause;
            CSR_ADDR_MTVAL:     rd_data_o = mtval;
            CSR_ADDR_MCYCLE:    rd_data_o = mcycle;
            CSR_ADDR_MINSTRET:  rd_data_o = minstret;
            CSR_ADDR_MVENDORID: rd_data_o = MVENDORID;
            CSR_ADDR_MARCHID:   rd_data_o = MARCHID;
            CSR_ADDR_MIMPID:    rd_data_o = MIMPID;
            CSR_ADDR_MHARTID:   rd_data_o = {{(XLEN-HART_W){1'b0}}, hartid_i};
            default:            rd_valid_o = 1'b0;       // Unimplemented
        endcase
    end

    assign mtvec_o    = mtvec;
    assign mepc_o     = mepc;
    assign mie_bit_o  = mie_bit;
    assign mpie_bit_o = mpie_bit;

endmodule

`default_nettype wire

// File: csr_access.sv
// CSR access unit, decodes Zicsr requests and issues register writes and responses
`default_nettype none

module csr_access (
    input  logic                          clk_i,
    input  logic                          rst_i,

    input  logic                          req_stb_i,  // Request valid
    input  secv_pkg::csr_req_t            req_i,      // Request payload
    input  logic                          suppress_i, // Trap or MRET this cycle

    output logic [11:0]                   rd_addr_o,  // Register file read address
    input  logic [secv_pkg::XLEN-1:0]     rd_data_i,  // Current CSR value
    input  logic                          rd_valid_i, // Address implemented

    output logic                          wr_stb_o,   // Register write strobe
    output secv_pkg::csr_wr_t             wr_o,       // Register write port

    output logic                          rsp_stb_o,  // Response valid
    output secv_pkg::csr_rsp_t            rsp_o       // Response payload
);

    import secv_pkg::*;

    logic [XLEN-1:0] src;                                // Register or immediate source
    logic            wr_intent;                          // Request would modify the CSR
    logic            read_only;                          // Address in 0xC00..0xFFF
    logic            illegal;                            // Request rejected
    logic [XLEN-1:0] new_val;                            // Read-modify-write result
    csr_rsp_t        rsp_d;                              // Next response

    assign rd_addr_o = req_i.addr;                       // Reads are combinational

    assign src = req_i.use_imm ? {{(XLEN-5){1'b0}}, req_i.imm} : req_i.rs_val;

    // RS and RC with a zero source only read
    assign wr_intent = (req_i.op == CSR_RW) || (src != '0);
    assign read_only = (req_i.addr[11:10] == 2'b11);
    assign illegal   = !rd_valid_i || (read_only && wr_intent);

    always_comb begin
        case (req_i.op)
            CSR_RS:  new_val = rd_data_i | src;          // Set
            CSR_RC:  new_val = rd_data_i & ~src;         // Clear
            default: new_val = src;                      // Swap
        endcase
    end

    // Register takes the value on the same edge as the response
    assign wr_stb_o  = req_stb_i && !illegal && wr_intent && !suppress_i;
    assign wr_o.addr = req_i.addr;
    assign wr_o.data = new_val;

    assign rsp_d.rdata   = illegal ? '0 : rd_data_i;     // Old value, zero if rejected
    assign rsp_d.illegal = illegal;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rsp_stb_o <= 1'b0;
        end else begin
            rsp_stb_o <= req_stb_i;                      // One cycle latency
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_stb_i) begin
            rsp_o <= rsp_d;                              // Payload held until next request
        end
    end

endmodule

`default_nettype wire

// File: secv_pkg.sv
// SEC-V CSR package with widths, CSR addresses, fixed ID values and shared types
`default_nettype none

package secv_pkg;

    localparam int XLEN   = 64;                          // Data width
    localparam int HART_W = 4;                           // Hart id input width

    // Machine trap setup and handling
    localparam logic [11:0] CSR_ADDR_MSTATUS   = 12'h300; // Machine status
    localparam logic [11:0] CSR_ADDR_MISA      = 12'h301; // ISA and extensions
    localparam logic [11:0] CSR_ADDR_MIE       = 12'h304; // Interrupt enable
    localparam logic [11:0] CSR_ADDR_MTVEC     = 12'h305; // Trap vector base
    localparam logic [11:0] CSR_ADDR_MSCRATCH  = 12'h340; // Scratch
    localparam logic [11:0] CSR_ADDR_MEPC      = 12'h341; // Exception PC
    localparam logic [11:0] CSR_ADDR_MCAUSE    = 12'h342; // Trap cause
    localparam logic [11:0] CSR_ADDR_MTVAL     = 12'h343; // Trap value

    // Counters
    localparam logic [11:0] CSR_ADDR_MCYCLE    = 12'hB00; // Cycle counter
    localparam logic [11:0] CSR_ADDR_MINSTRET  = 12'hB02; // Retired instructions

    // Identification, read-only space
    localparam logic [11:0] CSR_ADDR_MVENDORID = 12'hF11;
    localparam logic [11:0] CSR_ADDR_MARCHID   = 12'hF12;
    localparam logic [11:0] CSR_ADDR_MIMPID    = 12'hF13;
    localparam logic [11:0] CSR_ADDR_MHARTID   = 12'hF14;

    localparam logic [XLEN-1:0] MVENDORID = 64'h0000_0000_0000_0A5E; // Non-commercial id
    localparam logic [XLEN-1:0] MARCHID   = 64'h0000_0000_0000_0023; // Arch id
    localparam logic [XLEN-1:0] MIMPID    = 64'h0000_0000_0001_0000; // Impl version 1.0

    // MXL=2 in 63:62, U in bit 20, I in bit 8
    localparam logic [XLEN-1:0] MISA_VAL  = 64'h8000_0000_0010_0100;

    localparam int MSTATUS_MIE  = 3;                     // Global interrupt enable
    localparam int MSTATUS_MPIE = 7;                     // Previous MIE
    localparam int MSTATUS_MPP  = 11;                    // Low bit of fixed MPP field

    // Encoding follows funct3[1:0] of the CSR instructions
    typedef enum logic [1:0] {
        CSR_RW = 2'b01,                                  // Swap
        CSR_RS = 2'b10,                                  // Set bits
        CSR_RC = 2'b11                                   // Clear bits
    } csr_op_e;

    typedef struct packed {
        csr_op_e         op;                             // Operation
        logic            use_imm;                        // Immediate form
        logic [11:0]     addr;                           // CSR address
        logic [XLEN-1:0] rs_val;                         // rs1 value
        logic [4:0]      imm;                            // uimm field
    } csr_req_t;

    typedef struct packed {
        logic [XLEN-1:0] rdata;                          // Old CSR value
        logic            illegal;                        // Request rejected
    } csr_rsp_t;

    typedef struct packed {
        logic [11:0]     addr;                           // Target CSR
        logic [XLEN-1:0] data;                           // Unmasked write value
    } csr_wr_t;

    typedef struct packed {
        logic            is_int;                         // Interrupt, not exception
        logic [5:0]      cause;                          // Cause code
        logic [XLEN-1:0] pc;                             // PC of trapping instruction
        logic [XLEN-1:0] tval;                           // Faulting address or data
    } trap_req_t;

    typedef struct packed {
        logic            save;                           // Trap entry, write trap CSRs
        logic [XLEN-1:0] mepc;                           // New mepc
        logic [XLEN-1:0] mcause;                         // New mcause
        logic [XLEN-1:0] mtval;                          // New mtval
        logic            mie_bit;                        // New mstatus.MIE
        logic            mpie_bit;                       // New mstatus.MPIE
    } trap_upd_t;

endpackage

`default_nettype wire
